// ==== hw/dc_control_pkg.sv ====
`default_nettype none

package dc_control_pkg;

    //////////////////////////////
    // timing and widths
    //////////////////////////////

    // scaled down for simulation
    localparam logic [31:0] reset_hold_cycles = 32'd256;

    // waveform counter bit positions
    localparam int slow_glow_bit = 12;
    localparam int fast_glow_bit = 8;
    localparam int blink_bit = 10;
    localparam int wave_counter_width = 14;

    localparam int count_width = 32;
    localparam int apb_addr_width = 8;

    //////////////////////////////
    // enums
    //////////////////////////////

    typedef enum logic [1:0] {
        led_status,
        led_gdemu,
        led_usbgdrom,
        led_off
    } led_mode_t;

    // byte addresses of the register map
    typedef enum logic [7:0] {
        reg_control      = 8'h00,
        reg_status       = 8'h04,
        reg_pll54_loss   = 8'h08,
        reg_hdmi_loss    = 8'h0C,
        reg_resync_count = 8'h10
    } reg_addr_t;

endpackage

`default_nettype wire

// ==== hw/lock_monitor.sv ====
`default_nettype none

module lock_monitor import dc_control_pkg::*; (
    input  logic                   control_clock,
    input  logic                   reset_dc,
    input  logic                   pll54_locked,
    input  logic                   pll_hdmi_locked,
    input  logic                   resync,
    input  logic                   force_generate,
    output logic                   pll54_locked_sync,
    output logic                   pll_hdmi_locked_sync,
    output logic                   resync_sync,
    output logic                   force_generate_sync,
    output logic [count_width-1:0] pll54_loss_count,
    output logic [count_width-1:0] hdmi_loss_count,
    output logic [count_width-1:0] resync_count
);

    // bit 0 pll54, 1 hdmi pll, 2 resync, 3 force generate
    logic [3:0] sync_meta;
    logic [3:0] sync_level;
    // force generate has no edge counter
    logic [2:0] sync_prev;
    logic       pll54_fall;
    logic       hdmi_fall;
    logic       resync_rise;

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            sync_meta  <= '0;
            sync_level <= '0;
            sync_prev  <= '0;
        end else begin
            sync_meta  <= {force_generate, resync, pll_hdmi_locked, pll54_locked};
            sync_level <= sync_meta;
            sync_prev  <= sync_level[2:0];
        end
    end

    assign pll54_locked_sync    = sync_level[0];
    assign pll_hdmi_locked_sync = sync_level[1];
    assign resync_sync          = sync_level[2];
    assign force_generate_sync  = sync_level[3];

    // lock loss on falling edge, resync on rising edge
    assign pll54_fall  = sync_prev[0] & ~sync_level[0];
    assign hdmi_fall   = sync_prev[1] & ~sync_level[1];
    assign resync_rise = ~sync_prev[2] & sync_level[2];

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            pll54_loss_count <= '0;
            hdmi_loss_count  <= '0;
            resync_count     <= '0;
        end else begin
            if (pll54_fall) begin
                pll54_loss_count <= pll54_loss_count + 1'b1;
            end
            if (hdmi_fall) begin
                hdmi_loss_count <= hdmi_loss_count + 1'b1;
            end
            if (resync_rise) begin
                resync_count <= resync_count + 1'b1;
            end
        end
    end

    property step_by_one(logic [count_width-1:0] count);
        @(posedge control_clock) disable iff (reset_dc)
        !$past(reset_dc) |-> (count_width'(count - $past(count)) <= count_width'(1));
    endproperty

    a_pll54_step:  assert property (step_by_one(pll54_loss_count));
    a_hdmi_step:   assert property (step_by_one(hdmi_loss_count));
    a_resync_step: assert property (step_by_one(resync_count));

endmodule

`default_nettype wire

// ==== hw/console_reset_hold.sv ====
`default_nettype none

module console_reset_hold import dc_control_pkg::*; (
    input  logic control_clock,
    input  logic reset_dc,
    input  logic reset_req,
    output logic nreset
);

    logic [31:0] hold_count;

    // counter parks at reset_hold_cycles while idle
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            hold_count <= reset_hold_cycles;
            nreset     <= 1'b1;
        end else if (reset_req) begin
            // restart the hold even mid-hold
            hold_count <= '0;
            nreset     <= 1'b0;
        end else if (hold_count != reset_hold_cycles) begin
            hold_count <= hold_count + 32'd1;
            if (hold_count == reset_hold_cycles - 32'd1) begin
                nreset <= 1'b1;
            end
        end
    end

    a_count_bounded: assert property (
        @(posedge control_clock) disable iff (reset_dc)
        hold_count <= reset_hold_cycles
    );

endmodule

`default_nettype wire

// ==== hw/led_waveforms.sv ====
`default_nettype none

module led_waveforms import dc_control_pkg::*; (
    input  logic control_clock,
    input  logic reset_dc,
    output logic slow_glow,
    output logic fast_glow,
    output logic dim,
    output logic blink
);

    logic [wave_counter_width-1:0] wave_count;

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            wave_count <= '0;
        end else begin
            wave_count <= wave_count + 1'b1;
        end
    end

    //////////////////////////////
    // glow
    //////////////////////////////

    // bit pos picks ramp direction, the four bits under it the brightness
    function automatic logic glow_level(
        input logic [wave_counter_width-1:0] count,
        input int                            pos
    );
        logic [3:0] bright;
        bright = count[pos-1 -: 4];
        if (!count[pos]) begin
            bright = ~bright;
        end
        return bright > count[3:0];
    endfunction

    assign slow_glow = glow_level(wave_count, slow_glow_bit);
    assign fast_glow = glow_level(wave_count, fast_glow_bit);

    //////////////////////////////
    // dim and blink
    //////////////////////////////

    // one pwm slot out of sixteen
    assign dim   = (wave_count[3:0] == 4'd0);
    assign blink = wave_count[blink_bit];

endmodule

`default_nettype wire

// ==== hw/status_led_mux.sv ====
`default_nettype none

module status_led_mux import dc_control_pkg::*; (
    input  logic      control_clock,
    input  logic      reset_dc,
    input  led_mode_t led_mode,
    input  logic      pll_hdmi_locked_sync,
    input  logic      resync_sync,
    input  logic      force_generate_sync,
    input  logic      hdmi_out_ready,
    input  logic      slow_glow,
    input  logic      fast_glow,
    input  logic      dim,
    input  logic      blink,
    input  logic      console_nreset,
    input  logic      opt_nreset,
    output logic      status_led_level,
    output logic      status_led_oe
);

    logic status_level;

    // led is active low
    always_comb begin
        if (!pll_hdmi_locked_sync) begin
            status_level = ~dim;
        end else if (resync_sync) begin
            status_level = ~fast_glow;
        end else if (force_generate_sync) begin
            status_level = blink ? ~fast_glow : 1'b1;
        end else if (hdmi_out_ready) begin
            status_level = 1'b0;
        end else begin
            status_level = ~slow_glow;
        end
    end

    // open drain when the pin is shared with a reset line
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            status_led_level <= 1'b1;
            status_led_oe    <= 1'b0;
        end else begin
            case (led_mode)
                led_status: begin
                    status_led_level <= status_level;
                    status_led_oe    <= 1'b1;
                end
                led_gdemu: begin
                    status_led_level <= 1'b0;
                    status_led_oe    <= ~opt_nreset;
                end
                led_usbgdrom: begin
                    status_led_level <= 1'b0;
                    status_led_oe    <= ~console_nreset;
                end
                default: begin
                    status_led_level <= 1'b1;
                    status_led_oe    <= 1'b0;
                end
            endcase
        end
    end

    a_oe_known: assert property (
        @(posedge control_clock) disable iff (reset_dc)
        !$isunknown(status_led_oe)
    );

endmodule

`default_nettype wire

// ==== hw/control_regs.sv ====
`default_nettype none

module control_regs import dc_control_pkg::*; (
    input  logic                      control_clock,
    input  logic                      reset_dc,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [apb_addr_width-1:0] paddr,
    input  logic [31:0]               pwdata,
    input  logic                      pll54_locked_sync,
    input  logic                      pll_hdmi_locked_sync,
    input  logic                      resync_sync,
    input  logic                      force_generate_sync,
    input  logic                      console_nreset,
    input  logic                      opt_nreset,
    input  logic [count_width-1:0]    pll54_loss_count,
    input  logic [count_width-1:0]    hdmi_loss_count,
    input  logic [count_width-1:0]    resync_count,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    output logic                      console_reset_req,
    output logic                      opt_reset_req,
    output led_mode_t                 led_mode
);

    logic        access;
    logic        addr_valid;
    logic        control_wr;
    logic [31:0] read_value;

    // no wait states
    assign access = psel & penable;
    assign pready = access;

    //////////////////////////////
    // decode and read mux
    //////////////////////////////

    always_comb begin
        addr_valid = 1'b1;
        read_value = '0;
        case (paddr)
            reg_control: begin
                // request bits read as zero
                read_value = {28'd0, led_mode, 2'b00};
            end
            reg_status: begin
                read_value = {26'd0, force_generate_sync, resync_sync, opt_nreset,
                              console_nreset, pll_hdmi_locked_sync, pll54_locked_sync};
            end
            reg_pll54_loss:   read_value = pll54_loss_count;
            reg_hdmi_loss:    read_value = hdmi_loss_count;
            reg_resync_count: read_value = resync_count;
            default:          addr_valid = 1'b0;
        endcase
    end

    assign pslverr = access & ~addr_valid;
    assign prdata  = (access && !pwrite) ? read_value : '0;

    //////////////////////////////
    // control writes
    //////////////////////////////

    // other addresses are read only, writes dropped
    assign control_wr = access & pwrite & (paddr == reg_control);

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            console_reset_req <= 1'b0;
            opt_reset_req     <= 1'b0;
            led_mode          <= led_status;
        end else begin
            console_reset_req <= control_wr & pwdata[0];
            opt_reset_req     <= control_wr & pwdata[1];
            if (control_wr) begin
                led_mode <= led_mode_t'(pwdata[3:2]);
            end
        end
    end

    a_err_in_access: assert property (
        @(posedge control_clock) disable iff (reset_dc)
        pslverr |-> pready
    );

endmodule

`default_nettype wire

// ==== hw/dc_control_top.sv ====
`default_nettype none

module dc_control_top import dc_control_pkg::*; (
    input  logic                      control_clock,
    input  logic                      reset_dc,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [apb_addr_width-1:0] paddr,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    input  logic                      pll54_locked,
    input  logic                      pll_hdmi_locked,
    input  logic                      resync,
    input  logic                      force_generate,
    input  logic                      hdmi_out_ready,
    output logic                      console_nreset,
    output logic                      opt_nreset,
    output logic                      status_led_level,
    output logic                      status_led_oe
);

    logic                   pll54_locked_sync;
    logic                   pll_hdmi_locked_sync;
    logic                   resync_sync;
    logic                   force_generate_sync;
    logic [count_width-1:0] pll54_loss_count;
    logic [count_width-1:0] hdmi_loss_count;
    logic [count_width-1:0] resync_count;
    logic                   console_reset_req;
    logic                   opt_reset_req;
    led_mode_t              led_mode;
    logic                   slow_glow;
    logic                   fast_glow;
    logic                   dim;
    logic                   blink;

    //////////////////////////////
    // status inputs and bus
    //////////////////////////////

    lock_monitor u_lock_monitor (
        .control_clock        (control_clock),
        .reset_dc             (reset_dc),
        .pll54_locked         (pll54_locked),
        .pll_hdmi_locked      (pll_hdmi_locked),
        .resync               (resync),
        .force_generate       (force_generate),
        .pll54_locked_sync    (pll54_locked_sync),
        .pll_hdmi_locked_sync (pll_hdmi_locked_sync),
        .resync_sync          (resync_sync),
        .force_generate_sync  (force_generate_sync),
        .pll54_loss_count     (pll54_loss_count),
        .hdmi_loss_count      (hdmi_loss_count),
        .resync_count         (resync_count)
    );

    control_regs u_control_regs (
        .control_clock        (control_clock),
        .reset_dc             (reset_dc),
        .psel                 (psel),
        .penable              (penable),
        .pwrite               (pwrite),
        .paddr                (paddr),
        .pwdata               (pwdata),
        .pll54_locked_sync    (pll54_locked_sync),
        .pll_hdmi_locked_sync (pll_hdmi_locked_sync),
        .resync_sync          (resync_sync),
        .force_generate_sync  (force_generate_sync),
        .console_nreset       (console_nreset),
        .opt_nreset           (opt_nreset),
        .pll54_loss_count     (pll54_loss_count),
        .hdmi_loss_count      (hdmi_loss_count),
        .resync_count         (resync_count),
        .prdata               (prdata),
        .pready               (pready),
        .pslverr              (pslverr),
        .console_reset_req    (console_reset_req),
        .opt_reset_req        (opt_reset_req),
        .led_mode             (led_mode)
    );

    //////////////////////////////
    // reset pins
    //////////////////////////////

    console_reset_hold u_console_reset (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .reset_req     (console_reset_req),
        .nreset        (console_nreset)
    );

    console_reset_hold u_opt_reset (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .reset_req     (opt_reset_req),
        .nreset        (opt_nreset)
    );

    //////////////////////////////
    // status led
    //////////////////////////////

    led_waveforms u_led_waveforms (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .slow_glow     (slow_glow),
        .fast_glow     (fast_glow),
        .dim           (dim),
        .blink         (blink)
    );

    status_led_mux u_status_led_mux (
        .control_clock        (control_clock),
        .reset_dc             (reset_dc),
        .led_mode             (led_mode),
        .pll_hdmi_locked_sync (pll_hdmi_locked_sync),
        .resync_sync          (resync_sync),
        .force_generate_sync  (force_generate_sync),
        .hdmi_out_ready       (hdmi_out_ready),
        .slow_glow            (slow_glow),
        .fast_glow            (fast_glow),
        .dim                  (dim),
        .blink                (blink),
        .console_nreset       (console_nreset),
        .opt_nreset           (opt_nreset),
        .status_led_level     (status_led_level),
        .status_led_oe        (status_led_oe)
    );

endmodule

`default_nettype wire

// ==== dv/tb_apb_tasks.svh ====
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

// setup phase, then access phase held until pready
task automatic write_reg(
    input  logic [7:0]  addr,
    input  logic [31:0] data,
    output logic        err,
    output logic        ok
);
    int tries;
    tries = 0;
    @(posedge control_clock);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge control_clock);
    #1;
    penable = 1'b1;
    // sample mid cycle
    #2;
    while (!pready && tries < 16) begin
        @(posedge control_clock);
        #3;
        tries++;
    end
    ok  = pready;
    err = pslverr;
    @(posedge control_clock);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

task automatic read_reg(
    input  logic [7:0]  addr,
    output logic [31:0] data,
    output logic        err,
    output logic        ok
);
    int tries;
    tries = 0;
    @(posedge control_clock);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge control_clock);
    #1;
    penable = 1'b1;
    #2;
    while (!pready && tries < 16) begin
        @(posedge control_clock);
        #3;
        tries++;
    end
    ok   = pready;
    err  = pslverr;
    data = prdata;
    @(posedge control_clock);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
endtask

`endif

// ==== dv/tb_dc_control_top.sv ====
`default_nettype none

module tb_dc_control_top import dc_control_pkg::*; ();

    typedef enum int {op_write, op_read, op_set, op_wait, op_pins} op_t;

    // input bits: 0 pll54, 1 hdmi pll, 2 resync, 3 force generate, 4 out ready
    localparam logic [4:0] nominal_in    = 5'h13;
    localparam int         pll54_toggles = 3;
    localparam int         hdmi_toggles  = 2;
    localparam int         resync_pulses = 4;

    logic        control_clock = 1'b0;
    logic        reset_dc;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        pll54_locked;
    logic        pll_hdmi_locked;
    logic        resync;
    logic        force_generate;
    logic        hdmi_out_ready;
    logic        console_nreset;
    logic        opt_nreset;
    logic        status_led_level;
    logic        status_led_oe;

    op_t         ops[$];
    logic [7:0]  addrs[$];
    logic [31:0] datas[$];
    logic [31:0] expects[$];
    string       notes[$];

    integer seed;
    int     pass_count;
    int     fail_count;
    int     cycle_count;
    int     cycle_limit;

    dc_control_top u_dc_control_top (
        .control_clock    (control_clock),
        .reset_dc         (reset_dc),
        .psel             (psel),
        .penable          (penable),
        .pwrite           (pwrite),
        .paddr            (paddr),
        .pwdata           (pwdata),
        .prdata           (prdata),
        .pready           (pready),
        .pslverr          (pslverr),
        .pll54_locked     (pll54_locked),
        .pll_hdmi_locked  (pll_hdmi_locked),
        .resync           (resync),
        .force_generate   (force_generate),
        .hdmi_out_ready   (hdmi_out_ready),
        .console_nreset   (console_nreset),
        .opt_nreset       (opt_nreset),
        .status_led_level (status_led_level),
        .status_led_oe    (status_led_oe)
    );

    always #4 control_clock = ~control_clock;

    `include "tb_apb_tasks.svh"

    //////////////////////////////
    // stimulus table
    //////////////////////////////

    function automatic logic [31:0] status_word(
        input logic [4:0] in_bits,
        input logic       con,
        input logic       opt
    );
        return {26'd0, in_bits[3], in_bits[2], opt, con, in_bits[1], in_bits[0]};
    endfunction

    function automatic logic addr_in_map(input logic [7:0] addr);
        return addr == 8'h00 || addr == 8'h04 || addr == 8'h08 ||
               addr == 8'h0C || addr == 8'h10;
    endfunction

    task automatic add_entry(
        input op_t         op,
        input logic [7:0]  addr,
        input logic [31:0] data,
        input logic [31:0] exp,
        input string       note
    );
        ops.push_back(op);
        addrs.push_back(addr);
        datas.push_back(data);
        expects.push_back(exp);
        notes.push_back(note);
    endtask

    task automatic add_toggles(
        input logic [4:0]  active_in,
        input int          count,
        input logic [7:0]  count_addr,
        input string       name
    );
        int k;
        for (k = 0; k < count; k++) begin
            add_entry(op_set, 0, active_in, 0, {name, " event"});
            add_entry(op_wait, 0, 6, 0, "");
            if (k == 0) begin
                add_entry(op_read, reg_status, 0, status_word(active_in, 1'b1, 1'b1),
                          {name, " seen in status"});
            end
            add_entry(op_set, 0, nominal_in, 0, {name, " cleared"});
            add_entry(op_wait, 0, 6, 0, "");
        end
        add_entry(op_read, count_addr, 0, count, {name, " count"});
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        // state after reset
        add_entry(op_wait, 0, 6, 0, "");
        add_entry(op_read, reg_control, 0, 0, "control after reset");
        add_entry(op_read, reg_status, 0, status_word(nominal_in, 1'b1, 1'b1),
                  "status after reset");
        add_entry(op_read, reg_pll54_loss, 0, 0, "pll54 loss after reset");
        add_entry(op_read, reg_hdmi_loss, 0, 0, "hdmi loss after reset");
        add_entry(op_read, reg_resync_count, 0, 0, "resync count after reset");
        add_entry(op_read, 8'h20, 0, 0, "unmapped address");

        // event counters
        add_toggles(nominal_in & ~5'h01, pll54_toggles, reg_pll54_loss, "pll54 loss");
        add_toggles(nominal_in & ~5'h02, hdmi_toggles, reg_hdmi_loss, "hdmi loss");
        add_toggles(nominal_in | 5'h04, resync_pulses, reg_resync_count, "resync");

        // reset holds, pins as {level, oe, opt_nreset, console_nreset}
        add_entry(op_write, reg_control, 32'h1, 0, "console reset request");
        add_entry(op_wait, 0, 4, 0, "");
        add_entry(op_read, reg_status, 0, status_word(nominal_in, 1'b0, 1'b1),
                  "status in console hold");
        add_entry(op_pins, 8'h3, 0, 4'b0010, "console reset pins in hold");
        add_entry(op_wait, 0, reset_hold_cycles, 0, "");
        add_entry(op_read, reg_status, 0, status_word(nominal_in, 1'b1, 1'b1),
                  "status after console hold");
        add_entry(op_pins, 8'h3, 0, 4'b0011, "console reset pins released");
        add_entry(op_write, reg_control, 32'h2, 0, "optional reset request");
        add_entry(op_wait, 0, 4, 0, "");
        add_entry(op_read, reg_status, 0, status_word(nominal_in, 1'b1, 1'b0),
                  "status in optional hold");
        add_entry(op_pins, 8'h3, 0, 4'b0001, "optional reset pins in hold");
        add_entry(op_wait, 0, reset_hold_cycles, 0, "");
        add_entry(op_read, reg_status, 0, status_word(nominal_in, 1'b1, 1'b1),
                  "status after optional hold");
        add_entry(op_pins, 8'h3, 0, 4'b0011, "optional reset pins released");

        // led modes
        add_entry(op_pins, 8'hF, 0, 4'b0111, "led_status with output ready");
        add_entry(op_write, reg_control, 32'hC, 0, "select led_off");
        add_entry(op_wait, 0, 4, 0, "");
        add_entry(op_pins, 8'h7, 0, 4'b0011, "led_off pin released");
        add_entry(op_write, reg_control, 32'h6, 0, "led_gdemu with optional reset");
        add_entry(op_wait, 0, 4, 0, "");
        add_entry(op_pins, 8'hF, 0, 4'b0101, "led_gdemu in hold");
        add_entry(op_wait, 0, reset_hold_cycles, 0, "");
        add_entry(op_pins, 8'hF, 0, 4'b0011, "led_gdemu after hold");
        add_entry(op_write, reg_control, 32'h9, 0, "led_usbgdrom with console reset");
        add_entry(op_wait, 0, 4, 0, "");
        add_entry(op_pins, 8'hF, 0, 4'b0110, "led_usbgdrom in hold");
        add_entry(op_wait, 0, reset_hold_cycles, 0, "");
        add_entry(op_pins, 8'hF, 0, 4'b0011, "led_usbgdrom after hold");

        // read-only registers ignore writes
        rnd = $random(seed);
        add_entry(op_write, reg_status, rnd, 0, "random write to status");
        add_entry(op_read, reg_status, 0, status_word(nominal_in, 1'b1, 1'b1),
                  "status unchanged");
        rnd = $random(seed);
        add_entry(op_write, reg_pll54_loss, rnd, 0, "random write to pll54 loss");
        add_entry(op_read, reg_pll54_loss, 0, pll54_toggles, "pll54 loss unchanged");
        rnd = $random(seed);
        add_entry(op_write, reg_hdmi_loss, rnd, 0, "random write to hdmi loss");
        add_entry(op_read, reg_hdmi_loss, 0, hdmi_toggles, "hdmi loss unchanged");
        rnd = $random(seed);
        add_entry(op_write, reg_resync_count, rnd, 0, "random write to resync count");
        add_entry(op_read, reg_resync_count, 0, resync_pulses, "resync count unchanged");
        rnd = $random(seed);
        add_entry(op_write, reg_control, rnd, 0, "random led mode");
        add_entry(op_read, reg_control, 0, {28'd0, rnd[3:2], 2'b00}, "led mode read back");
    endtask

    //////////////////////////////
    // checking
    //////////////////////////////

    task automatic check_value(
        input int          idx,
        input string       name,
        input logic [31:0] exp,
        input logic [31:0] act
    );
        if (act !== exp) begin
            $display("** Error entry %0d (%s): %s expected %08h, got %08h",
                     idx, notes[idx], name, exp, act);
            fail_count++;
        end else begin
            $display("pass entry %0d (%s): %s = %08h", idx, notes[idx], name, act);
            pass_count++;
        end
    endtask

    task automatic run_entry(input int idx);
        logic [31:0] rdata;
        logic        err;
        logic        ok;
        logic [3:0]  pins;
        logic [3:0]  mask;
        case (ops[idx])
            op_write, op_read: begin
                if (ops[idx] == op_write) begin
                    write_reg(addrs[idx], datas[idx], err, ok);
                end else begin
                    read_reg(addrs[idx], rdata, err, ok);
                end
                if (!ok) begin
                    $display("entry %0d (%s): no pready within 16 cycles", idx, notes[idx]);
                    fail_count++;
                end else begin
                    check_value(idx, "pslverr", {31'd0, !addr_in_map(addrs[idx])},
                                {31'd0, err});
                    if (ops[idx] == op_read && addr_in_map(addrs[idx])) begin
                        check_value(idx, "prdata", expects[idx], rdata);
                    end
                end
            end
            op_set: begin
                @(posedge control_clock);
                #1;
                {hdmi_out_ready, force_generate, resync, pll_hdmi_locked, pll54_locked} =
                    datas[idx][4:0];
            end
            op_wait: begin
                repeat (datas[idx]) @(posedge control_clock);
            end
            op_pins: begin
                @(posedge control_clock);
                #3;
                mask = addrs[idx][3:0];
                pins = {status_led_level, status_led_oe, opt_nreset, console_nreset};
                check_value(idx, "led_level/led_oe/opt_nreset/console_nreset",
                            {28'd0, expects[idx][3:0] & mask}, {28'd0, pins & mask});
            end
            default: begin
            end
        endcase
    endtask

    always @(posedge control_clock) begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        int i;
        int wait_sum;
        seed            = 32'h28aafa99;
        pass_count      = 0;
        fail_count      = 0;
        cycle_count     = 0;
        cycle_limit     = 0;
        reset_dc        = 1'b1;
        psel            = 1'b0;
        penable         = 1'b0;
        pwrite          = 1'b0;
        paddr           = '0;
        pwdata          = '0;
        {hdmi_out_ready, force_generate, resync, pll_hdmi_locked, pll54_locked} = nominal_in;

        build_table();
        wait_sum = 0;
        for (i = 0; i < ops.size(); i++) begin
            if (ops[i] == op_wait) begin
                wait_sum += datas[i];
            end
        end
        cycle_limit = wait_sum + 10 * ops.size();

        repeat (2) @(posedge control_clock);
        #1;
        reset_dc = 1'b0;

        for (i = 0; i < ops.size(); i++) begin
            run_entry(i);
        end

        $display("checks: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+dv
hw/dc_control_pkg.sv
hw/lock_monitor.sv
hw/console_reset_hold.sv
hw/led_waveforms.sv
hw/status_led_mux.sv
hw/control_regs.sv
hw/dc_control_top.sv
dv/tb_dc_control_top.sv

// ==== Bender.yml ====
package:
  name: dc_control

sources:
  - hw/dc_control_pkg.sv
  - hw/lock_monitor.sv
  - hw/console_reset_hold.sv
  - hw/led_waveforms.sv
  - hw/status_led_mux.sv
  - hw/control_regs.sv
  - hw/dc_control_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_dc_control_top.sv
